/* files.f */
+incdir+src
src/apb_pkg.sv
src/irq_pkg.sv
src/periph_reg_if.sv
src/apb_front_end.sv
src/timer_bank.sv
src/irq_ctrl.sv
src/periph_subsystem.sv
verif/tb_clk_gen.sv
verif/tb_periph_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_periph_subsystem -f files.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

/* verif/tb_periph_subsystem.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module tb_periph_subsystem
    import apb_pkg::*;
    import irq_pkg::*;
();

    localparam int     MAX_CYCLES = 4000; // Well above the length of all tests
    localparam paddr_t IRQ_BASE   = 12'h800;
    localparam paddr_t EN_ADDR    = 12'h880;
    localparam paddr_t TH_ADDR    = 12'h884;
    localparam paddr_t CLAIM_ADDR = 12'h888;

    logic     clk_i;
    logic     arst_n_i;
    logic     psel_i;
    logic     penable_i;
    logic     pwrite_i;
    paddr_t   paddr_i;
    pdata_t   pwdata_i;
    pdata_t   prdata_o;
    logic     pready_o;
    logic     pslverr_o;
    ext_irq_t ext_irq_i;
    logic     irq_o;

    // Reference model state
    logic [31:0] lfsr;
    irq_vec_t    m_pend;
    irq_vec_t    m_insvc;
    irq_vec_t    m_en;
    prio_t       m_prio [1:`N_IRQ_SRC]; // Indexed by source id
    prio_t       m_thresh;
    logic [1:0]  m_tflag;
    ext_irq_t    ext_q;
    int          quiet  = 0; // Negedges since the last model change
    int          cycles = 0;

    tb_clk_gen i_clk_gen (
        .clk_o    ( clk_i    ),
        .arst_n_o ( arst_n_i )
    );

    periph_subsystem dut0 (.*);

    // ------------------------------
    // Model and random source
    // ------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Highest priority above threshold, lowest id on ties
    function automatic irq_id_t expected_claim();
        irq_id_t id;
        id = '0;
        for (int k = `N_IRQ_SRC; k >= 1; k--) begin
            if (m_pend[k-1] && m_en[k-1] && m_prio[k] > m_thresh &&
                (id == '0 || m_prio[k] >= m_prio[id])) begin
                id = irq_id_t'(k);
            end
        end
        return id;
    endfunction

    task automatic note_change();
        m_pend = m_pend | ({ext_q, m_tflag} & ~m_insvc); // Level sources re-arm
        quiet  = 0;
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input pdata_t exp, input pdata_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_id(input string name, input irq_id_t exp, input irq_id_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // ------------------------------
    // APB access
    // ------------------------------
    task automatic apb_xfer(input logic wr, input paddr_t addr, input pdata_t wdata,
                            input logic setup, input logic exp_err, output pdata_t rdata);
        for (int ph = setup ? 0 : 1; ph < 2; ph++) begin
            @(posedge clk_i);
            psel_i    <= 1'b1;
            penable_i <= (ph == 1);
            pwrite_i  <= wr;
            paddr_i   <= addr;
            pwdata_i  <= wdata;
        end
        @(negedge clk_i);
        rdata = prdata_o;
        check_bit("pready_o", 1'b1, pready_o);
        check_bit("pslverr_o", exp_err, pslverr_o);
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic wr_reg(input paddr_t addr, input pdata_t data);
        pdata_t unused;
        apb_xfer(1'b1, addr, data, 1'b1, 1'b0, unused);
        quiet = 0;
    endtask

    task automatic rd_reg(input paddr_t addr, output pdata_t data);
        apb_xfer(1'b0, addr, '0, 1'b1, 1'b0, data);
    endtask

    task automatic rw_check(input string name, input paddr_t addr, input pdata_t mask,
                            output pdata_t exp);
        pdata_t val;
        pdata_t rd;
        val = rand_bits(32) | 32'h0001_0000; // Keeps compare values far above the counter
        wr_reg(addr, val);
        rd_reg(addr, rd);
        exp = val & mask;
        check_data(name, exp, rd);
    endtask

    task automatic set_ext(input ext_irq_t v);
        @(posedge clk_i);
        ext_irq_i <= v;
        ext_q = v;
        note_change();
    endtask

    task automatic claim_and_check(output irq_id_t id);
        pdata_t rd;
        id = expected_claim();
        rd_reg(CLAIM_ADDR, rd);
        check_id("claim", id, irq_id_t'(rd));
        if (id != '0) begin
            m_pend[id-1]  = 1'b0;
            m_insvc[id-1] = 1'b1;
        end
        note_change();
    endtask

    task automatic complete_id(input irq_id_t id);
        wr_reg(CLAIM_ADDR, pdata_t'(id));
        m_insvc[id-1] = 1'b0;
        note_change();
    endtask

    // irq_o against the model, two edges after each change
    always @(negedge clk_i) begin
        if (arst_n_i && quiet >= 2) begin
            check_bit("irq_o", expected_claim() != '0, irq_o);
        end else begin
            quiet = quiet + 1;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        irq_id_t id;
        pdata_t  rd;
        pdata_t  val;
        int      c;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        ext_irq_i = '0;
        ext_q     = '0;
        lfsr      = 32'h67c1;
        m_pend    = '0;
        m_insvc   = '0;
        m_en      = '0;
        m_thresh  = '0;
        m_tflag   = '0;
        m_prio    = '{default: '0};
        wait (arst_n_i);

        // Readback
        for (int k = 1; k <= `N_IRQ_SRC; k++) begin
            rw_check("prio", IRQ_BASE + paddr_t'(4 * k), 32'h7, val);
            m_prio[k] = prio_t'(val);
        end
        rw_check("enable", EN_ADDR, 32'h3ff, val);
        rw_check("threshold", TH_ADDR, 32'h7, val);
        for (int t = 0; t < `TIMER_CNT; t++) begin
            rw_check("cmp", paddr_t'(16 * t + 4), '1, val);
            rw_check("ctrl", paddr_t'(16 * t + 8), 32'h1, val);
            wr_reg(paddr_t'(16 * t + 8), '0);
        end
        wr_reg(EN_ADDR, '0);
        wr_reg(TH_ADDR, 32'h5); // Region 3 aliases this offset

        // Unmapped regions 1 and 3, then an access cycle with no setup
        for (int r = 1; r < 4; r += 2) begin
            apb_xfer(1'b1, paddr_t'(r * 1024 + 'h84), '1, 1'b1, 1'b1, rd);
            apb_xfer(1'b0, paddr_t'(r * 1024 + 'h84), '0, 1'b1, 1'b1, rd);
            check_data("prdata_o", '0, rd);
        end
        apb_xfer(1'b1, TH_ADDR, '1, 1'b0, 1'b1, rd);
        rd_reg(TH_ADDR, rd);
        check_data("threshold", 32'h5, rd);
        wr_reg(TH_ADDR, '0);

        // ------------------------------
        // Timer match and claim
        // ------------------------------
        for (int t = 0; t < `TIMER_CNT; t++) begin
            c = 4 + int'(rand_bits(6) % 37);
            wr_reg(paddr_t'(16 * t), '0);
            wr_reg(paddr_t'(16 * t + 4), pdata_t'(c));
            wr_reg(paddr_t'(16 * t + 8), 32'h1);
            repeat (c + 10) @(posedge clk_i);
            rd_reg(paddr_t'(16 * t + 12), rd);
            check_data("status", 32'h1, rd);
            rd_reg(paddr_t'(16 * t), rd);
            if (rd > pdata_t'(c)) begin
                $display("Timer %0d counter reads %0d, above its compare value %0d", t, rd, c);
                abort_run();
            end
            m_tflag[t] = 1'b1;
            note_change();
            val = pdata_t'(1 + rand_bits(8) % 7);
            wr_reg(IRQ_BASE + paddr_t'(4 * (t + 1)), val);
            m_prio[t + 1] = prio_t'(val);
            wr_reg(EN_ADDR, pdata_t'(1) << t);
            m_en = irq_vec_t'(1) << t;
            repeat (3) @(posedge clk_i);
            claim_and_check(id);
            check_id("timer claim", irq_id_t'(t + 1), id);
            wr_reg(paddr_t'(16 * t + 8), '0);
            wr_reg(paddr_t'(16 * t + 12), 32'h1);
            m_tflag[t] = 1'b0;
            rd_reg(paddr_t'(16 * t + 12), rd);
            check_data("status", '0, rd);
            complete_id(id);
        end

        // Claim ordering on random external patterns
        for (int r = 0; r < 8; r++) begin
            for (int k = 3; k <= `N_IRQ_SRC; k++) begin
                val = rand_bits(`PRIO_W);
                wr_reg(IRQ_BASE + paddr_t'(4 * k), val);
                m_prio[k] = prio_t'(val);
            end
            val = rand_bits(`N_IRQ_SRC);
            wr_reg(EN_ADDR, val);
            m_en = irq_vec_t'(val);
            set_ext(ext_irq_t'(rand_bits(`N_EXT_IRQ)));
            do begin
                repeat (3) @(posedge clk_i);
                claim_and_check(id);
                if (id > 2) begin
                    set_ext(ext_q & ~(ext_irq_t'(1) << (id - 3))); // Drop before complete
                    complete_id(id);
                end
            end while (id != '0);
        end

        // ------------------------------
        // Threshold masking
        // ------------------------------
        wr_reg(TH_ADDR, 32'h4);
        m_thresh = 3'd4;
        for (int k = 3; k <= `N_IRQ_SRC; k++) begin
            val = rand_bits(`PRIO_W) % 5;
            wr_reg(IRQ_BASE + paddr_t'(4 * k), val);
            m_prio[k] = prio_t'(val);
        end
        wr_reg(EN_ADDR, 32'h3fc);
        m_en = 10'h3fc;
        set_ext('1);
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        check_bit("irq_o", 1'b0, irq_o);
        claim_and_check(id);
        check_id("masked claim", '0, id);
        c = 3 + int'(rand_bits(3));
        val = pdata_t'(5 + rand_bits(2) % 3);
        wr_reg(IRQ_BASE + paddr_t'(4 * c), val);
        m_prio[c] = prio_t'(val);
        rd_reg(IRQ_BASE + paddr_t'(4 * c), rd);
        check_data("prio", val, rd);
        repeat (3) @(posedge clk_i);
        claim_and_check(id);
        check_id("threshold claim", irq_id_t'(c), id);
        set_ext('0);
        complete_id(id);
        repeat (4) @(posedge clk_i);

        $display("TB PASSED");
        $finish;
    end

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o; // 8 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

/* src/periph_subsystem.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_subsystem
    import apb_pkg::*;
    import irq_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    // APB slave
    input  logic     psel_i,
    input  logic     penable_i,
    input  logic     pwrite_i,
    input  paddr_t   paddr_i,
    input  pdata_t   pwdata_i,
    output pdata_t   prdata_o,
    output logic     pready_o,
    output logic     pslverr_o,
    // Interrupts
    input  ext_irq_t ext_irq_i,
    output logic     irq_o
);

    logic [`TIMER_CNT-1:0] timer_irq;

    periph_reg_if timer_reg ();
    periph_reg_if irq_reg ();

    // ------------------------------
    // Bus front end
    // ------------------------------
    apb_front_end i_apb_front_end (
        .clk_i     ( clk_i     ),
        .arst_n_i  ( arst_n_i  ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .timer_reg ( timer_reg ),
        .irq_reg   ( irq_reg   )
    );

    // ------------------------------
    // Timers and interrupt control
    // ------------------------------
    timer_bank i_timer_bank (
        .clk_i       ( clk_i     ),
        .arst_n_i    ( arst_n_i  ),
        .reg_bus     ( timer_reg ),
        .timer_irq_o ( timer_irq )
    );

    irq_ctrl i_irq_ctrl (
        .clk_i       ( clk_i     ),
        .arst_n_i    ( arst_n_i  ),
        .reg_bus     ( irq_reg   ),
        .timer_irq_i ( timer_irq ),
        .ext_irq_i   ( ext_irq_i ),
        .irq_o       ( irq_o     ) // Single target
    );

endmodule

/* src/irq_ctrl.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module irq_ctrl
    import apb_pkg::*;
    import irq_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    periph_reg_if.slave           reg_bus,
    input  logic [`TIMER_CNT-1:0] timer_irq_i,
    input  ext_irq_t              ext_irq_i,
    output logic                  irq_o
);

    // Word addresses, byte offset divided by 4
    localparam logic [7:0] WORD_ENABLE = 8'h20; // 0x080
    localparam logic [7:0] WORD_THRESH = 8'h21; // 0x084
    localparam logic [7:0] WORD_CLAIM  = 8'h22; // 0x088

    irq_vec_t   src;
    irq_vec_t   pending_q;
    irq_vec_t   in_service_q;
    irq_vec_t   enable_q;
    prio_t      prio_q [`N_IRQ_SRC];
    prio_t      thresh_q;
    logic       irq_q;

    logic [7:0] word;
    logic       wr_en;
    logic       claim_rd;
    logic       complete_wr;
    irq_id_t    wr_id;
    irq_vec_t   prio_sel;
    irq_vec_t   claim_mask;
    irq_vec_t   complete_mask;
    irq_id_t    best_id;
    prio_t      best_prio;

    assign src         = {ext_irq_i, timer_irq_i}; // Timers take ids 1 and 2
    assign word        = reg_bus.addr[9:2];
    assign wr_en       = reg_bus.req && reg_bus.we;
    assign claim_rd    = reg_bus.req && !reg_bus.we && (word == WORD_CLAIM);
    assign complete_wr = wr_en && (word == WORD_CLAIM);
    assign wr_id       = reg_bus.wdata[`IRQ_ID_W-1:0];

    // ------------------------------
    // Priority search
    // ------------------------------
    // Strictly greater keeps the lowest id on ties
    always_comb begin
        best_id   = '0;
        best_prio = thresh_q;
        for (int k = 0; k < `N_IRQ_SRC; k++) begin
            if (pending_q[k] && enable_q[k] && (prio_q[k] > best_prio)) begin
                best_id   = irq_id_t'(k + 1);
                best_prio = prio_q[k];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `N_IRQ_SRC; k++) begin
            prio_sel[k]      = wr_en && (word == 8'(k + 1));
            claim_mask[k]    = claim_rd && (best_id == irq_id_t'(k + 1));
            complete_mask[k] = complete_wr && (wr_id == irq_id_t'(k + 1));
        end
    end

    // ------------------------------
    // Gateway state and registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q    <= '0;
            in_service_q <= '0;
            enable_q     <= '0;
            prio_q       <= '{default: '0};
            thresh_q     <= '0;
            irq_q        <= 1'b0;
        end else begin
            // Claim clears pending before the level can re-arm it
            pending_q    <= (pending_q | (src & ~in_service_q)) & ~claim_mask;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
            irq_q        <= (best_id != '0);

            if (wr_en && word == WORD_ENABLE) begin
                enable_q <= reg_bus.wdata[`N_IRQ_SRC-1:0];
            end
            if (wr_en && word == WORD_THRESH) begin
                thresh_q <= reg_bus.wdata[`PRIO_W-1:0];
            end
            for (int k = 0; k < `N_IRQ_SRC; k++) begin
                if (prio_sel[k]) begin
                    prio_q[k] <= reg_bus.wdata[`PRIO_W-1:0];
                end
            end
        end
    end

    assign irq_o = irq_q;

    // Read return, id 0 priority reads as zero
    always_comb begin
        reg_bus.rdata = '0;
        for (int k = 0; k < `N_IRQ_SRC; k++) begin
            if (word == 8'(k + 1)) begin
                reg_bus.rdata = pdata_t'(prio_q[k]);
            end
        end
        case (word)
            WORD_ENABLE: reg_bus.rdata = pdata_t'(enable_q);
            WORD_THRESH: reg_bus.rdata = pdata_t'(thresh_q);
            WORD_CLAIM:  reg_bus.rdata = pdata_t'(best_id);
            default: ;
        endcase
    end

endmodule

/* src/timer_bank.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module timer_bank
    import apb_pkg::*;
    import irq_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    periph_reg_if.slave           reg_bus,
    output logic [`TIMER_CNT-1:0] timer_irq_o
);

    // Word offsets inside one timer
    localparam logic [1:0] REG_CNT    = 2'd0;
    localparam logic [1:0] REG_CMP    = 2'd1;
    localparam logic [1:0] REG_CTRL   = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3;

    pdata_t                cnt_q [`TIMER_CNT];
    pdata_t                cmp_q [`TIMER_CNT];
    logic [`TIMER_CNT-1:0] en_q;
    logic [`TIMER_CNT-1:0] flag_q;

    logic                  in_range;
    logic                  wr_en;
    tmr_idx_t              sel_idx;
    logic [1:0]            reg_sel;
    logic [`TIMER_CNT-1:0] wr_tmr;
    logic [`TIMER_CNT-1:0] match;

    // ------------------------------
    // Register decode
    // ------------------------------
    assign in_range = (reg_bus.addr[`PERIPH_ADDR_W-1:5] == '0);
    assign wr_en    = reg_bus.req && reg_bus.we && in_range;
    assign sel_idx  = reg_bus.addr[4]; // 16 bytes per timer
    assign reg_sel  = reg_bus.addr[3:2];

    always_comb begin
        for (int i = 0; i < `TIMER_CNT; i++) begin
            wr_tmr[i] = wr_en && (sel_idx == tmr_idx_t'(i));
            match[i]  = en_q[i] && (cnt_q[i] == cmp_q[i]);
        end
    end

    // ------------------------------
    // Counters and flags
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= '{default: '0};
            cmp_q  <= '{default: '0};
            en_q   <= '0;
            flag_q <= '0;
        end else begin
            for (int i = 0; i < `TIMER_CNT; i++) begin
                if (wr_tmr[i] && reg_sel == REG_CNT) begin
                    cnt_q[i] <= reg_bus.wdata;
                end else if (match[i]) begin
                    cnt_q[i] <= '0; // Wrap on compare
                end else if (en_q[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end

                if (wr_tmr[i] && reg_sel == REG_CMP) begin
                    cmp_q[i] <= reg_bus.wdata;
                end
                if (wr_tmr[i] && reg_sel == REG_CTRL) begin
                    en_q[i] <= reg_bus.wdata[0];
                end

                // New match beats a clear in the same cycle
                if (match[i]) begin
                    flag_q[i] <= 1'b1;
                end else if (wr_tmr[i] && reg_sel == REG_STATUS && reg_bus.wdata[0]) begin
                    flag_q[i] <= 1'b0;
                end
            end
        end
    end

    // Read return
    always_comb begin
        reg_bus.rdata = '0;
        if (in_range) begin
            case (reg_sel)
                REG_CNT:    reg_bus.rdata = cnt_q[sel_idx];
                REG_CMP:    reg_bus.rdata = cmp_q[sel_idx];
                REG_CTRL:   reg_bus.rdata = pdata_t'(en_q[sel_idx]);
                REG_STATUS: reg_bus.rdata = pdata_t'(flag_q[sel_idx]);
                default:    reg_bus.rdata = '0;
            endcase
        end
    end

    assign timer_irq_o = flag_q;

endmodule

/* src/apb_front_end.sv */
`timescale 1ns/1ps
`include "periph_macros.svh"

module apb_front_end
    import apb_pkg::*;
(
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  logic         psel_i,
    input  logic         penable_i,
    input  logic         pwrite_i,
    input  paddr_t       paddr_i,
    input  pdata_t       pwdata_i,
    output pdata_t       prdata_o,
    output logic         pready_o,
    output logic         pslverr_o,
    periph_reg_if.master timer_reg,
    periph_reg_if.master irq_reg
);

    apb_state_e state_q;
    apb_state_e state_d;
    logic [1:0] region;
    logic       access;
    logic       setup_ok;
    logic       timer_hit;
    logic       irq_hit;
    logic       bus_err;
    logic       acc_ok;

    // ------------------------------
    // Phase tracking
    // ------------------------------
    always_comb begin
        state_d = APB_IDLE;
        if (psel_i) begin
            state_d = penable_i ? APB_ACCESS : APB_SETUP;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= APB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign access   = psel_i && penable_i;
    assign setup_ok = (state_q == APB_SETUP); // Access must follow a setup cycle

    // ------------------------------
    // Region decode
    // ------------------------------
    assign region    = paddr_i[`PERIPH_ADDR_W-1:`PERIPH_ADDR_W-2];
    assign timer_hit = (region == `TIMER_REGION);
    assign irq_hit   = (region == `IRQ_REGION);

    assign bus_err = access && (!setup_ok || !(timer_hit || irq_hit));
    assign acc_ok  = access && !bus_err;

    assign timer_reg.req   = acc_ok && timer_hit;
    assign timer_reg.we    = pwrite_i;
    assign timer_reg.addr  = {2'b00, paddr_i[`PERIPH_ADDR_W-3:0]};
    assign timer_reg.wdata = pwdata_i;

    assign irq_reg.req   = acc_ok && irq_hit;
    assign irq_reg.we    = pwrite_i;
    assign irq_reg.addr  = {2'b00, paddr_i[`PERIPH_ADDR_W-3:0]};
    assign irq_reg.wdata = pwdata_i;

    always_comb begin
        prdata_o = '0; // Zero on error or idle
        if (acc_ok && timer_hit) begin
            prdata_o = timer_reg.rdata;
        end else if (acc_ok && irq_hit) begin
            prdata_o = irq_reg.rdata;
        end
    end

    assign pready_o  = 1'b1; // No wait states
    assign pslverr_o = bus_err;

endmodule

/* src/periph_reg_if.sv */
`timescale 1ns/1ps

interface periph_reg_if
    import apb_pkg::*;
();

    logic   req;   // One cycle per accepted access
    logic   we;
    paddr_t addr;  // Offset inside the region
    pdata_t wdata;
    pdata_t rdata; // Combinational from the slave

    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

/* src/irq_pkg.sv */
`include "periph_macros.svh"

package irq_pkg;

    // ------------------------------
    // Interrupt side types
    // ------------------------------
    typedef logic [`N_IRQ_SRC-1:0] irq_vec_t; // bit k is id k+1
    typedef logic [`PRIO_W-1:0]    prio_t;
    typedef logic [`IRQ_ID_W-1:0]  irq_id_t;  // 0 means none
    typedef logic [`N_EXT_IRQ-1:0] ext_irq_t;

    // Timer select inside the timer bank
    typedef logic [$clog2(`TIMER_CNT)-1:0] tmr_idx_t;

endpackage

/* src/apb_pkg.sv */
`include "periph_macros.svh"

package apb_pkg;

    // ------------------------------
    // APB side types
    // ------------------------------
    typedef logic [`PERIPH_ADDR_W-1:0] paddr_t;
    typedef logic [`PERIPH_DATA_W-1:0] pdata_t;

    // Phase seen on the bus in the previous cycle
    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

endpackage

/* src/periph_macros.svh */
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define PERIPH_ADDR_W 12
`define PERIPH_DATA_W 32

// ------------------------------
// Timer and interrupt counts
// ------------------------------
`define TIMER_CNT 2
`define N_EXT_IRQ 8
`define N_IRQ_SRC 10 // ids 1..2 timers, 3..10 external lines
`define PRIO_W    3
`define IRQ_ID_W  4

// Address bits 11:10 select the target block
`define TIMER_REGION 2'd0 // 0x000 - 0x3FF
`define IRQ_REGION   2'd2 // 0x800 - 0xBFF

`endif
